/* logic/uart_pkg.sv */
package uart_pkg;

    typedef logic [7:0] uart_byte_t;  // One data byte
    typedef logic [3:0] credit_t;     // Credit count, caps depth at 15
    typedef logic [3:0] tick_cnt_t;   // Oversample tick within a bit

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    // Word delivered to the host
    typedef struct packed {
        uart_byte_t data;
        logic       frame_err;  // Stop bit sampled low
    } rx_word_t;

endpackage

/* logic/uart_baud_gen.sv */
module uart_baud_gen #(
    parameter int CLKS_PER_TICK = 4
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int CW = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;

    logic [CW-1:0] cnt;
    logic          wrap;

    // Free running from reset, shared by both directions
    assign wrap = (cnt == CW'(CLKS_PER_TICK - 1));

    always_ff @(posedge clk) begin
        if (!rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            tick <= wrap;  // One cycle per period
            if (wrap) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* logic/uart_tx_fifo.sv */
module uart_tx_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               tx_push,
    input  uart_pkg::uart_byte_t tx_byte,
    input  logic               tx_busy,
    output logic               tx_req,
    output uart_pkg::uart_byte_t tx_data,
    output logic               tx_credit
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    uart_pkg::uart_byte_t mem [FIFO_DEPTH];
    logic [PW-1:0]        wr_ptr;
    logic [PW-1:0]        rd_ptr;
    uart_pkg::credit_t    count;
    logic                 pop;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        if (ptr == PW'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Hand over the head byte once the transmitter is free
    assign pop       = (count != '0) && !tx_busy;
    assign tx_req    = pop;
    assign tx_data   = mem[rd_ptr];
    assign tx_credit = pop;  // Credit goes back with the pop

    always_ff @(posedge clk) begin
        if (tx_push) begin
            mem[wr_ptr] <= tx_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (tx_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({tx_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Host must hold a credit, a pop in the same cycle frees one
    push_while_full: assert property (
        @(posedge clk) disable iff (!rst)
        tx_push |-> (count < uart_pkg::credit_t'(FIFO_DEPTH)) || pop
    );

    count_in_range: assert property (
        @(posedge clk) disable iff (!rst)
        count <= uart_pkg::credit_t'(FIFO_DEPTH)
    );

endmodule

/* logic/uart_tx.sv */
module uart_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tick,
    input  logic                 tx_req,
    input  uart_pkg::uart_byte_t tx_data,
    output logic                 tx_busy,
    output logic                 tx_line
);

    uart_pkg::tx_state_e  state;
    uart_pkg::tick_cnt_t  tick_cnt;
    logic [2:0]           bit_idx;
    uart_pkg::uart_byte_t data_sr;
    logic                 load;
    logic                 bit_end;
    logic                 shift;

    assign load    = (state == uart_pkg::TX_IDLE) && tx_req;
    assign bit_end = tick && (tick_cnt == 4'd15);  // 16th tick of a bit
    assign shift   = bit_end && ((state == uart_pkg::TX_START) || (state == uart_pkg::TX_DATA));

    // Byte shifter, LSB goes out first
    always_ff @(posedge clk) begin
        if (load) begin
            data_sr <= tx_data;
        end else if (shift) begin
            data_sr <= data_sr >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= uart_pkg::TX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            tx_busy  <= 1'b0;
            tx_line  <= 1'b1;
        end else begin
            case (state)
                uart_pkg::TX_IDLE: begin
                    tx_line <= 1'b1;
                    if (tx_req) begin
                        tx_busy  <= 1'b1;
                        tick_cnt <= '0;
                        state    <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: begin
                    if (tick) begin
                        if (tx_line) begin
                            tx_line <= 1'b0;  // Start bit aligned to a tick
                        end else if (bit_end) begin
                            tx_line  <= data_sr[0];
                            tick_cnt <= '0;
                            bit_idx  <= '0;
                            state    <= uart_pkg::TX_DATA;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            tx_line <= 1'b1;  // Stop bit
                            state   <= uart_pkg::TX_STOP;
                        end else begin
                            tx_line <= data_sr[0];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                uart_pkg::TX_STOP: begin
                    if (bit_end) begin
                        tx_busy <= 1'b0;
                        state   <= uart_pkg::TX_IDLE;
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

    // Queue only hands over while the transmitter is free
    no_req_while_busy: assert property (
        @(posedge clk) disable iff (!rst)
        tx_req |-> !tx_busy
    );

endmodule

/* logic/uart_rx.sv */
module uart_rx #(
    parameter int RX_CREDITS = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               tick,
    input  logic               rx_line,
    input  logic               rx_credit,
    output logic               rx_valid,
    output uart_pkg::rx_word_t rx_word,
    output logic               rx_overrun
);

    logic                 rx_meta;
    logic                 rx_sync;
    logic                 rx_prev;
    uart_pkg::rx_state_e  state;
    uart_pkg::tick_cnt_t  tick_cnt;
    logic [2:0]           bit_idx;
    uart_pkg::uart_byte_t data_sr;
    uart_pkg::credit_t    credits;
    logic                 bit_end;
    logic                 stop_done;
    logic                 take;

    assign bit_end   = tick && (tick_cnt == 4'd15);  // Mid-bit sample point
    assign stop_done = (state == uart_pkg::RX_STOP) && bit_end;
    assign take      = stop_done && (credits != '0);

    // Two-flop synchronizer plus edge history
    always_ff @(posedge clk) begin
        if (!rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == uart_pkg::RX_DATA) && bit_end) begin
            data_sr <= {rx_sync, data_sr[7:1]};  // LSB arrives first
        end
        if (take) begin
            rx_word.data      <= data_sr;
            rx_word.frame_err <= !rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= uart_pkg::RX_IDLE;
            tick_cnt   <= '0;
            bit_idx    <= '0;
            rx_valid   <= 1'b0;
            rx_overrun <= 1'b0;
            credits    <= uart_pkg::credit_t'(RX_CREDITS);
        end else begin
            rx_valid   <= take;
            rx_overrun <= stop_done && !take;  // Dropped for lack of credit
            credits    <= credits - uart_pkg::credit_t'(take)
                        + uart_pkg::credit_t'(rx_credit);
            case (state)
                uart_pkg::RX_IDLE: begin
                    if (rx_prev && !rx_sync) begin
                        tick_cnt <= '0;
                        state    <= uart_pkg::RX_START;
                    end
                end
                uart_pkg::RX_START: begin
                    if (tick && (tick_cnt == 4'd7)) begin
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                        // Glitch if the line is back high
                        state    <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= uart_pkg::RX_STOP;
                        end
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (bit_end) begin
                        state <= uart_pkg::RX_IDLE;
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    // Host may only return credits it was given
    credit_overflow: assert property (
        @(posedge clk) disable iff (!rst)
        (rx_credit && !take) |-> (credits < uart_pkg::credit_t'(RX_CREDITS))
    );

endmodule

/* logic/uart_top.sv */
module uart_top #(
    parameter int CLKS_PER_TICK = 4,
    parameter int FIFO_DEPTH    = 4,
    parameter int RX_CREDITS    = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tx_push,
    input  uart_pkg::uart_byte_t tx_byte,
    input  logic                 rx_line,
    input  logic                 rx_credit,
    output logic                 tx_line,
    output logic                 tx_credit,
    output logic                 rx_valid,
    output uart_pkg::rx_word_t   rx_word,
    output logic                 rx_overrun
);

    logic                 tick;     // 16x oversample
    logic                 tx_req;
    logic                 tx_busy;
    uart_pkg::uart_byte_t tx_data;

    uart_baud_gen #(
        .CLKS_PER_TICK(CLKS_PER_TICK)
    ) u_baud (
        .clk (clk),
        .rst (rst),
        .tick(tick)
    );

    uart_tx_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_tx_fifo (
        .clk      (clk),
        .rst      (rst),
        .tx_push  (tx_push),
        .tx_byte  (tx_byte),
        .tx_busy  (tx_busy),
        .tx_req   (tx_req),
        .tx_data  (tx_data),
        .tx_credit(tx_credit)
    );

    uart_tx u_tx (
        .clk    (clk),
        .rst    (rst),
        .tick   (tick),
        .tx_req (tx_req),
        .tx_data(tx_data),
        .tx_busy(tx_busy),
        .tx_line(tx_line)
    );

    uart_rx #(
        .RX_CREDITS(RX_CREDITS)
    ) u_rx (
        .clk       (clk),
        .rst       (rst),
        .tick      (tick),
        .rx_line   (rx_line),
        .rx_credit (rx_credit),
        .rx_valid  (rx_valid),
        .rx_word   (rx_word),
        .rx_overrun(rx_overrun)
    );

endmodule

/* dv/tb_clk_gen.sv */
module tb_clk_gen #(
    parameter int PERIOD     = 4,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released on a falling edge, like the other DUT inputs
    initial begin
        rst = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule

/* dv/uart_checker.sv */
module uart_checker #(
    parameter int BIT_CYCLES = 64
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tx_push,
    input  uart_pkg::uart_byte_t tx_byte,
    input  logic                 tx_line,
    input  logic                 tx_credit,
    input  logic                 rx_valid,
    input  uart_pkg::rx_word_t   rx_word,
    input  logic                 rx_overrun,
    input  logic                 exp_push,
    input  logic [9:0]           exp_entry,  // {drop, data, frame_err}
    output int                   errors,
    output int                   pending,
    output int                   tx_pending,
    output int                   credits,
    output int                   overruns
);

    logic [9:0]           exp_q[$];
    uart_pkg::uart_byte_t tx_q[$];
    uart_pkg::uart_byte_t cur;
    logic [9:0]           head;
    logic                 prev_line;
    logic                 lvl;
    int                   pos = -1;  // Cycle inside the frame

    always @(posedge clk) begin
        if (!rst) begin
            exp_q.delete();
            tx_q.delete();
            pos        = -1;
            prev_line  = 1'b1;
            errors     = 0;
            credits    = 0;
            overruns   = 0;
        end else begin
            if (tx_push) tx_q.push_back(tx_byte);
            if (exp_push) exp_q.push_back(exp_entry);
            if (tx_credit) credits++;
            if (rx_overrun) overruns++;
            if (pos >= 0) begin
                // Start bit must hold low for exactly BIT_CYCLES samples
                if (pos < BIT_CYCLES) lvl = 1'b0;
                else if (pos >= 9 * BIT_CYCLES) lvl = 1'b1;
                else lvl = cur[3'(pos / BIT_CYCLES - 1)];
                if (tx_line !== lvl) begin
                    $display("** Error at %0t: tx_line in frame %02h bit %0d expected %b got %b",
                             $time, cur, pos / BIT_CYCLES, lvl, tx_line);
                    errors++;
                end
                pos = (pos == 10 * BIT_CYCLES - 1) ? -1 : pos + 1;
            end else if (prev_line && !tx_line) begin
                if (tx_q.size() == 0) begin
                    $display("%0t: frame started on tx_line with no byte pushed", $time);
                    errors++;
                end else begin
                    cur = tx_q.pop_front();
                    pos = 1;  // This sample is the first low one
                end
            end
            if (rx_valid || rx_overrun) begin
                if (exp_q.size() == 0) begin
                    $display("%0t: receiver output with no byte expected", $time);
                    errors++;
                end else begin
                    head = exp_q.pop_front();
                    if (head[9] != rx_overrun) begin
                        $display("%0t: byte %02h should have been %s", $time, head[8:1],
                                 head[9] ? "dropped by an overrun" : "delivered");
                        errors++;
                    end else if (rx_valid && rx_word !== head[8:0]) begin
                        $display("** Error at %0t: rx_word expected %02h/%b got %02h/%b",
                                 $time, head[8:1], head[0], rx_word.data, rx_word.frame_err);
                        errors++;
                    end
                end
            end
            prev_line = tx_line;
        end
        pending    = exp_q.size();
        tx_pending = tx_q.size() + ((pos >= 0) ? 1 : 0);
    end

endmodule

/* dv/uart_tb.sv */
module uart_tb;

    localparam int CLK_PERIOD    = 4;
    localparam int CLKS_PER_TICK = 4;
    localparam int FIFO_DEPTH    = 4;
    localparam int RX_CREDITS    = 2;
    localparam int BIT_CYCLES    = 16 * CLKS_PER_TICK;
    localparam int WAIT_LIMIT    = 4000;  // Several frames

    logic                 clk;
    logic                 rst;
    logic                 tx_push;
    uart_pkg::uart_byte_t tx_byte;
    logic                 rx_line;
    logic                 rx_credit = 1'b0;
    logic                 tx_line;
    logic                 tx_credit;
    logic                 rx_valid;
    uart_pkg::rx_word_t   rx_word;
    logic                 rx_overrun;
    logic                 inject_mode;
    logic                 inj_line;
    logic                 hold_credit = 1'b0;
    logic                 exp_push;
    logic [9:0]           exp_entry;
    int                   owed = 0;         // Receive credits not yet returned
    int                   tx_returned = 0;
    int                   pushed;
    int                   tb_errs;
    int                   n_ok;
    int                   n_bad;
    integer               seed;
    int                   chk_errors;
    int                   chk_pending;
    int                   chk_tx_pending;
    int                   chk_credits;
    int                   chk_overruns;

    tb_clk_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(5)) u_clk_gen (.clk(clk), .rst(rst));

    assign rx_line = inject_mode ? inj_line : tx_line;  // Loopback unless injecting

    uart_top #(
        .CLKS_PER_TICK(CLKS_PER_TICK),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .RX_CREDITS   (RX_CREDITS)
    ) u_dut (
        .clk(clk), .rst(rst), .tx_push(tx_push), .tx_byte(tx_byte), .rx_line(rx_line),
        .rx_credit(rx_credit), .tx_line(tx_line), .tx_credit(tx_credit),
        .rx_valid(rx_valid), .rx_word(rx_word), .rx_overrun(rx_overrun)
    );

    uart_checker #(.BIT_CYCLES(BIT_CYCLES)) u_checker (
        .clk(clk), .rst(rst), .tx_push(tx_push), .tx_byte(tx_byte), .tx_line(tx_line),
        .tx_credit(tx_credit), .rx_valid(rx_valid), .rx_word(rx_word),
        .rx_overrun(rx_overrun), .exp_push(exp_push), .exp_entry(exp_entry),
        .errors(chk_errors), .pending(chk_pending), .tx_pending(chk_tx_pending),
        .credits(chk_credits), .overruns(chk_overruns)
    );

    always @(posedge clk) begin
        if (rst && tx_credit) tx_returned <= tx_returned + 1;
    end

    // Receive credit goes back the cycle after rx_valid
    always @(negedge clk) begin
        rx_credit = (owed > 0) && !hold_credit;
        if (rx_credit) owed = owed - 1;
        if (rx_valid) owed = owed + 1;
    end

    function automatic int tx_avail();
        return FIFO_DEPTH + tx_returned - pushed;
    endfunction

    task automatic send_byte(input uart_pkg::uart_byte_t b, input logic drop);
        int n;
        n = 0;
        while (tx_avail() <= 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (tx_avail() <= 0) begin
            $display("%0t: timeout waiting for a transmit credit", $time);
            tb_errs++;
            return;
        end
        tx_push   = 1'b1;
        tx_byte   = b;
        exp_push  = 1'b1;
        exp_entry = {drop, b, 1'b0};
        pushed++;
        @(negedge clk);
        tx_push  = 1'b0;
        exp_push = 1'b0;
    endtask

    task automatic inject_frame(input uart_pkg::uart_byte_t b, input logic stop);
        logic [9:0] bits;
        bits      = {stop, b, 1'b0};
        exp_push  = 1'b1;
        exp_entry = {1'b0, b, !stop};
        @(negedge clk);
        exp_push = 1'b0;
        repeat (10) begin
            inj_line = bits[0];
            bits     = bits >> 1;
            repeat (BIT_CYCLES) @(negedge clk);
        end
        inj_line = 1'b1;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((chk_pending != 0 || chk_tx_pending != 0) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (chk_pending != 0 || chk_tx_pending != 0) begin
            $display("%0t: timeout waiting for %0d frames and %0d received bytes", $time,
                     chk_tx_pending, chk_pending);
            tb_errs++;
        end
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        int errs;
        errs = tb_errs + chk_errors - errs_before;
        if (errs == 0) begin
            n_ok++;
            $display("%0t: test %0d %s ok", $time, num, name);
        end else begin
            n_bad++;
            $display("%0t: test %0d %s FAILED with %0d errors", $time, num, name, errs);
        end
    endtask

    initial begin
        int          e0;
        int          c0;
        int          n;
        logic [31:0] rnd;
        tx_push     = 1'b0;
        tx_byte     = '0;
        exp_push    = 1'b0;
        exp_entry   = '0;
        inj_line    = 1'b1;
        inject_mode = 1'b1;  // Line held idle through reset
        pushed      = 0;
        tb_errs     = 0;
        n_ok        = 0;
        n_bad       = 0;
        seed        = 32'h7b46_cc60;
        n = 0;
        while (rst !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rst !== 1'b1) begin
            $display("%0t: timeout waiting for reset release", $time);
            tb_errs++;
        end
        @(negedge clk);

        e0 = tb_errs + chk_errors;
        inject_mode = 1'b0;
        repeat (100) begin
            @(negedge clk);
            if (tx_line !== 1'b1 || tx_credit !== 1'b0 || rx_valid !== 1'b0
                    || rx_overrun !== 1'b0) begin
                $display("** Error at %0t: tx_line,tx_credit,rx_valid,rx_overrun expected %s",
                         $time, $sformatf("1000 got %b%b%b%b", tx_line, tx_credit, rx_valid,
                         rx_overrun));
                tb_errs++;
            end
        end
        end_test(1, "reset state", e0);

        e0 = tb_errs + chk_errors;
        repeat (30) begin
            rnd = $random(seed);
            send_byte(rnd[7:0], 1'b0);
        end
        wait_drain();
        end_test(2, "loopback data", e0);

        e0 = tb_errs + chk_errors;
        c0 = chk_credits;
        if (tx_avail() != FIFO_DEPTH) begin
            $display("%0t: only %0d transmit credits held before the burst", $time, tx_avail());
            tb_errs++;
        end
        repeat (FIFO_DEPTH) begin
            rnd = $random(seed);
            send_byte(rnd[7:0], 1'b0);
        end
        wait_drain();
        if (chk_credits - c0 != FIFO_DEPTH) begin
            $display("** Error at %0t: tx_credit pulses expected %0d got %0d", $time,
                     FIFO_DEPTH, chk_credits - c0);
            tb_errs++;
        end
        end_test(3, "transmit credits and bit timing", e0);

        e0 = tb_errs + chk_errors;
        c0 = chk_overruns;
        @(posedge clk);
        hold_credit = 1'b1;
        @(negedge clk);
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            send_byte(rnd[7:0], i >= RX_CREDITS);  // Later bytes find no credit
        end
        wait_drain();
        if (chk_overruns - c0 != 4 - RX_CREDITS) begin
            $display("** Error at %0t: rx_overrun pulses expected %0d got %0d", $time,
                     4 - RX_CREDITS, chk_overruns - c0);
            tb_errs++;
        end
        @(posedge clk);
        hold_credit = 1'b0;
        n = 0;
        while (owed != 0 && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (owed != 0) begin
            $display("%0t: timeout waiting for receive credits to go back", $time);
            tb_errs++;
        end
        @(negedge clk);
        rnd = $random(seed);
        send_byte(rnd[7:0], 1'b0);
        wait_drain();
        end_test(4, "receive back-pressure", e0);

        e0 = tb_errs + chk_errors;
        inject_mode = 1'b1;
        repeat (2 * BIT_CYCLES) @(negedge clk);
        rnd = $random(seed);
        inject_frame(rnd[7:0], 1'b0);
        repeat (2 * BIT_CYCLES) @(negedge clk);
        rnd = $random(seed);
        inject_frame(rnd[7:0], 1'b1);
        wait_drain();
        inject_mode = 1'b0;
        end_test(5, "frame error", e0);

        $display("Summary: %0d tests ok, %0d tests not ok, %0d errors", n_ok, n_bad,
                 tb_errs + chk_errors);
        if (n_bad == 0 && tb_errs + chk_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
logic/uart_pkg.sv
logic/uart_baud_gen.sv
logic/uart_tx_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_top.sv
dv/tb_clk_gen.sv
dv/uart_checker.sv
dv/uart_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the UART testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
    --top-module uart_tb \
    -f vlog.f \
    --Mdir obj_dir -o uart_sim

status=0
./obj_dir/uart_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failed" sim.log || [ "$status" -ne 0 ]; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation clean"
